//--- src/picc_defines.svh
// ---------------------------------------
// PICC frame check constants
// bit timing, frame delay and CRC_A values
// shared by RTL and the CRC reference model
// ---------------------------------------

`ifndef PICC_DEFINES_SVH
`define PICC_DEFINES_SVH

// carrier clocks per transmitted bit, must be at least four so the
// CRC snapshot taken by the serializer has settled
`define PICC_TX_BIT_PERIOD 8

// carrier clocks from the received eoc to the transmit trigger
`define PICC_FDT_CYCLES 64

// CRC_A start value and reflected generator polynomial
`define PICC_CRC_A_PRESET 16'h6363
`define PICC_CRC_A_POLY   16'h8408

`endif

//--- src/frame_pkg.sv
// ---------------------------------------
// frame stream types
// receive bits, transmit bits, transmit
// bytes and the serializer FSM states
// ---------------------------------------

package frame_pkg;

    // bit stream from the receive decoder
    // soc and eoc frame the bits, data is only meaningful with data_valid
    typedef struct packed {
        logic soc;
        logic eoc;
        logic data_valid;
        logic data;
    } rx_bits_t;

    // bit stream towards the load modulator
    // data_valid covers the whole frame, req strobes each bit
    typedef struct packed {
        logic data_valid;
        logic req;
        logic data;
    } tx_bits_t;

    // one byte from the transmit byte source, last marks the final data byte
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } tx_byte_t;

    typedef enum logic [2:0] {
        WAIT_FDT,
        DATA,
        CRC_LO,
        CRC_HI,
        IDLE
    } tx_state_e;

endpackage

//--- src/crc_pkg.sv
// ---------------------------------------
// CRC_A types
// CRC value and the engine source select
// ---------------------------------------

package crc_pkg;

    // CRC_A is 16 bits wide, bit 0 is the first bit to leave the register
    typedef logic [15:0] crc_t;

    // which bit stream currently feeds the shared engine
    // receive and transmit never overlap, the FDT keeps them apart
    typedef enum logic {
        CRC_RX,
        CRC_TX
    } crc_source_e;

endpackage

//--- src/crc_a.sv
// ---------------------------------------
// CRC_A engine
// bit-serial CRC over an LSB-first stream
// start loads the preset, sample shifts
// ---------------------------------------

`timescale 1ns/1ps
`include "picc_defines.svh"

module crc_a (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          start,
    input  logic          sample,
    input  logic          data,
    output crc_pkg::crc_t crc
);

    crc_pkg::crc_t crc_next;
    logic          feedback;

    // the register is reflected so bit 0 meets the incoming bit first
    assign feedback = crc[0] ^ data;

    // shift right and fold in the polynomial when the feedback bit is set
    assign crc_next = (crc >> 1) ^ (feedback ? `PICC_CRC_A_POLY : 16'h0000);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc <= `PICC_CRC_A_PRESET;
        end else if (start) begin
            // a new frame always begins from the preset
            crc <= `PICC_CRC_A_PRESET;
        end else if (sample) begin
            crc <= crc_next;
        end
    end

    // the controller must not restart the engine while a bit is being taken
    a_no_start_with_sample: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(start && sample)
    );

endmodule

//--- src/crc_control.sv
// ---------------------------------------
// CRC source control
// steers the receive or transmit bits into
// the shared CRC_A engine and flags a good
// received frame
// ---------------------------------------

`timescale 1ns/1ps

module crc_control (
    input  logic                clk,
    input  logic                rst_n,
    input  frame_pkg::rx_bits_t rx_bits,
    input  frame_pkg::tx_bits_t tx_bits,
    input  logic                tx_append_crc,
    input  logic                fdt_trigger,
    output logic                rx_crc_ok,
    output crc_pkg::crc_t       crc
);

    crc_pkg::crc_source_e crc_source;
    logic                 crc_start;
    logic                 crc_sample;
    logic                 crc_data;

    crc_a u_crc_a (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (crc_start),
        .sample (crc_sample),
        .data   (crc_data),
        .crc    (crc)
    );

    // running the CRC over a frame plus its own CRC bytes leaves zero
    assign rx_crc_ok = (crc == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc_source <= crc_pkg::CRC_RX;
            crc_start  <= 1'b0;
            crc_sample <= 1'b0;
        end else begin
            // start and sample are single cycle strobes
            crc_start  <= 1'b0;
            crc_sample <= 1'b0;

            // a new received frame takes the engine back for receive
            if (rx_bits.soc) begin
                crc_source <= crc_pkg::CRC_RX;
                crc_start  <= 1'b1;
            end

            // the transmit CRC is only needed when it will be appended
            if (fdt_trigger && tx_bits.data_valid && tx_append_crc) begin
                crc_source <= crc_pkg::CRC_TX;
                crc_start  <= 1'b1;
            end

            if (crc_source == crc_pkg::CRC_RX) begin
                crc_sample <= rx_bits.data_valid;
            end else begin
                crc_sample <= tx_bits.req;
            end
        end
    end

    // the data bit lines up with the sample strobe one cycle later
    always_ff @(posedge clk) begin
        if (crc_source == crc_pkg::CRC_RX) begin
            crc_data <= rx_bits.data;
        end else begin
            crc_data <= tx_bits.req ? tx_bits.data : crc_data;
        end
    end

    // bit strobes on both streams are isolated pulses, so neither
    // engine strobe can repeat on the next cycle
    a_start_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        crc_start |=> !crc_start
    );

    a_sample_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        crc_sample |=> !crc_sample
    );

endmodule

//--- src/fdt_timer.sv
// ---------------------------------------
// frame delay timer
// counts a fixed delay from the received
// eoc and pulses the transmit trigger
// ---------------------------------------

`timescale 1ns/1ps
`include "picc_defines.svh"

module fdt_timer (
    input  logic                clk,
    input  logic                rst_n,
    input  frame_pkg::rx_bits_t rx_bits,
    output logic                fdt_trigger
);

    localparam int CNT_W = $clog2(`PICC_FDT_CYCLES);

    logic [CNT_W-1:0] count;
    logic             counting;

    // eoc loads FDT-1, so the zero count falls exactly FDT cycles after eoc
    assign fdt_trigger = counting && (count == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count    <= '0;
            counting <= 1'b0;
        end else if (rx_bits.eoc) begin
            count    <= CNT_W'(`PICC_FDT_CYCLES - 1);
            counting <= 1'b1;
        end else if (rx_bits.soc) begin
            // the reader sent another frame, so there is nothing to answer yet
            counting <= 1'b0;
        end else if (counting) begin
            if (count == '0) begin
                counting <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- src/tx_bit_serializer.sv
// ---------------------------------------
// transmit bit serializer
// waits for the FDT trigger, sends bytes
// LSB first at one bit per bit period and
// optionally appends the CRC_A bytes
// ---------------------------------------

`timescale 1ns/1ps
`include "picc_defines.svh"

module tx_bit_serializer (
    input  logic                clk,
    input  logic                rst_n,
    input  frame_pkg::tx_byte_t tx_byte,
    input  logic                tx_byte_valid,
    input  logic                tx_append_crc,
    input  logic                fdt_trigger,
    input  crc_pkg::crc_t       crc,
    output logic                tx_byte_ready,
    output frame_pkg::tx_bits_t tx_bits
);

    localparam int PERIOD = `PICC_TX_BIT_PERIOD;
    localparam int PCNT_W = $clog2(PERIOD);

    frame_pkg::tx_state_e state;
    logic [7:0]           shift_reg;
    logic [7:0]           crc_hi;
    logic [2:0]           bit_cnt;
    logic [PCNT_W-1:0]    period_cnt;
    logic                 empty;
    logic                 last_byte;
    logic                 sending;
    logic                 take_byte;
    logic                 byte_done;
    logic                 crc_load;

    assign sending = (state == frame_pkg::DATA) || (state == frame_pkg::CRC_LO) ||
                     (state == frame_pkg::CRC_HI);

    // a bit goes out whenever the period counter has run down and
    // the shift register holds something
    assign tx_bits.req  = sending && !empty && (period_cnt == '0);
    assign tx_bits.data = shift_reg[0];

    // before the trigger the frame is announced as soon as a byte is offered
    assign tx_bits.data_valid = (state == frame_pkg::WAIT_FDT) ? tx_byte_valid : sending;

    // the first byte is taken on the trigger, later ones whenever the register empties
    assign tx_byte_ready = ((state == frame_pkg::WAIT_FDT) && fdt_trigger) ||
                           ((state == frame_pkg::DATA) && empty);
    assign take_byte = tx_byte_ready && tx_byte_valid;

    assign byte_done = tx_bits.req && (bit_cnt == 3'd7);

    // one cycle before the first CRC bit the engine has already
    // absorbed the last data bit because the period is at least four
    assign crc_load = (state == frame_pkg::CRC_LO) && empty && (period_cnt == PCNT_W'(1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= frame_pkg::WAIT_FDT;
            bit_cnt    <= '0;
            period_cnt <= '0;
            empty      <= 1'b1;
            last_byte  <= 1'b0;
        end else begin
            // the period counter restarts on each bit and parks at zero
            // while waiting for a slow byte source
            if (tx_bits.req) begin
                period_cnt <= PCNT_W'(PERIOD - 1);
                bit_cnt    <= bit_cnt + 1'b1;
            end else if (period_cnt != '0) begin
                period_cnt <= period_cnt - 1'b1;
            end

            if (take_byte) begin
                empty     <= 1'b0;
                last_byte <= tx_byte.last;
            end

            case (state)
                frame_pkg::WAIT_FDT: begin
                    if (take_byte) begin
                        // first bit goes out on the very next cycle
                        state      <= frame_pkg::DATA;
                        period_cnt <= '0;
                        bit_cnt    <= '0;
                    end
                end
                frame_pkg::DATA: begin
                    if (byte_done) begin
                        empty <= 1'b1;
                        if (last_byte) begin
                            state <= tx_append_crc ? frame_pkg::CRC_LO : frame_pkg::IDLE;
                        end
                    end
                end
                frame_pkg::CRC_LO: begin
                    if (crc_load) begin
                        empty <= 1'b0;
                    end else if (byte_done) begin
                        state <= frame_pkg::CRC_HI;
                    end
                end
                frame_pkg::CRC_HI: begin
                    if (byte_done) begin
                        state <= frame_pkg::IDLE;
                        empty <= 1'b1;
                    end
                end
                default: begin
                    // data_valid drops for this cycle to close the frame
                    state <= frame_pkg::WAIT_FDT;
                end
            endcase
        end
    end

    // the high CRC byte waits in crc_hi while the
    // engine keeps absorbing the CRC bits that are sent
    always_ff @(posedge clk) begin
        if (take_byte) begin
            shift_reg <= tx_byte.data;
        end else if (crc_load) begin
            shift_reg <= crc[7:0];
            crc_hi    <= crc[15:8];
        end else if ((state == frame_pkg::CRC_LO) && byte_done) begin
            shift_reg <= crc_hi;
        end else if (tx_bits.req) begin
            shift_reg <= shift_reg >> 1;
        end
    end

    // the frame is already announced on the cycle before any bit leaves
    a_req_in_frame: assert property (
        @(posedge clk) disable iff (!rst_n)
        tx_bits.req |-> tx_bits.data_valid && $past(tx_bits.data_valid)
    );

    // bits never come closer together than one bit period
    a_req_spacing: assert property (
        @(posedge clk) disable iff (!rst_n)
        tx_bits.req |=> (!tx_bits.req) [*PERIOD-1]
    );

endmodule

//--- src/picc_crc_top.sv
// ---------------------------------------
// PICC frame check top level
// receive CRC check, frame delay timer and
// transmit serializer around one CRC_A
// ---------------------------------------

`timescale 1ns/1ps

module picc_crc_top (
    input  logic                clk,
    input  logic                rst_n,
    input  frame_pkg::rx_bits_t rx_bits,
    input  frame_pkg::tx_byte_t tx_byte,
    input  logic                tx_byte_valid,
    input  logic                tx_append_crc,
    output logic                tx_byte_ready,
    output frame_pkg::tx_bits_t tx_bits,
    output logic                rx_crc_ok
);

    logic          fdt_trigger;
    crc_pkg::crc_t crc;

    // the engine sees the transmit bits that leave the serializer
    crc_control u_crc_control (
        .clk           (clk),
        .rst_n         (rst_n),
        .rx_bits       (rx_bits),
        .tx_bits       (tx_bits),
        .tx_append_crc (tx_append_crc),
        .fdt_trigger   (fdt_trigger),
        .rx_crc_ok     (rx_crc_ok),
        .crc           (crc)
    );

    fdt_timer u_fdt_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .rx_bits     (rx_bits),
        .fdt_trigger (fdt_trigger)
    );

    tx_bit_serializer u_tx_bit_serializer (
        .clk           (clk),
        .rst_n         (rst_n),
        .tx_byte       (tx_byte),
        .tx_byte_valid (tx_byte_valid),
        .tx_append_crc (tx_append_crc),
        .fdt_trigger   (fdt_trigger),
        .crc           (crc),
        .tx_byte_ready (tx_byte_ready),
        .tx_bits       (tx_bits)
    );

endmodule

//--- dv/crc_a_model.svh
// ----------------------------------------
// CRC_A reference model
// byte-wise CRC_A over a queue of bytes,
// in the table-free form of the standard
// ----------------------------------------

`ifndef CRC_A_MODEL_SVH
`define CRC_A_MODEL_SVH

`include "picc_defines.svh"

// frames are handled as byte queues, first byte on air first
typedef logic [7:0] byte_q_t[$];

// this byte-wise update is equivalent to eight bit-serial steps
// through the reflected polynomial 8408 hex
function automatic logic [15:0] crc_a_of_bytes(input byte_q_t bytes);
    logic [15:0] crc;
    logic [7:0]  ch;
    crc = `PICC_CRC_A_PRESET;
    foreach (bytes[i]) begin
        ch  = bytes[i] ^ crc[7:0];
        ch  = ch ^ (ch << 4);
        crc = (crc >> 8) ^ {ch, 8'h00} ^ {5'b00000, ch, 3'b000} ^ {12'h000, ch[7:4]};
    end
    return crc;
endfunction

`endif

//--- dv/picc_crc_tb.sv
// ----------------------------------------
// PICC frame check testbench
// drives receive frames and transmit bytes
// and checks CRC results and bit timing
// ----------------------------------------

`timescale 1ns/1ps
`include "picc_defines.svh"

module picc_crc_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int MAX_RX_BYTES = 5;
    localparam int MAX_TX_BYTES = 4;
    // worst case lengths of one receive frame and one request plus answer
    localparam int RX_CYCLES = (MAX_RX_BYTES + 2) * 8 * 2 + 8;
    localparam int TX_CYCLES = RX_CYCLES + `PICC_FDT_CYCLES +
                               (MAX_TX_BYTES + 4) * 8 * `PICC_TX_BIT_PERIOD + 8;
    localparam int RUN_CYCLES = 16 + 3 * RX_CYCLES + 3 * TX_CYCLES;

    logic                clk;
    logic                rst_n;
    frame_pkg::rx_bits_t rx_bits;
    frame_pkg::tx_byte_t tx_byte;
    logic                tx_byte_valid;
    logic                tx_append_crc;
    logic                tx_byte_ready;
    frame_pkg::tx_bits_t tx_bits;
    logic                rx_crc_ok;

    int   cycle = 0;
    int   errors = 0;
    int   eoc_cycle = 0;
    int   first_req_cycle = 0;
    int   last_req_cycle = 0;
    logic have_req = 1'b0;
    logic byte_offered = 1'b0;
    logic seen_bits[$];

    `include "crc_a_model.svh"

    picc_crc_top DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .rx_bits       (rx_bits),
        .tx_byte       (tx_byte),
        .tx_byte_valid (tx_byte_valid),
        .tx_append_crc (tx_append_crc),
        .tx_byte_ready (tx_byte_ready),
        .tx_bits       (tx_bits),
        .rx_crc_ok     (rx_crc_ok)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // cycle count, read half a cycle or a drive delay after the edge
    always @(posedge clk) begin
        cycle = cycle + 1;
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("mismatch at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
        $display("Done: errors found");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("error at %0t ns: %s", $time, what);
        $display("Done: errors found");
        $fatal(1, "stopping at the first error");
    endtask

    initial begin
        #(2 * RUN_CYCLES * CLK_PERIOD);
        report_failure("watchdog expired before the test sequence finished");
    end

    // the transmit side stays silent until a byte source shows up
    a_quiet_after_reset: assert property (
        @(posedge clk) disable iff (!rst_n)
        !byte_offered |-> !(tx_bits.req || tx_bits.data_valid || tx_byte_ready)
    ) else report_mismatch("tx_bits.req/tx_bits.data_valid/tx_byte_ready", 32'h0,
                           32'({tx_bits.req, tx_bits.data_valid, tx_byte_ready}));

    // collects every transmitted bit and checks the req spacing inside a frame
    always @(negedge clk) begin
        if (rst_n) begin
            if (!tx_bits.data_valid) begin
                have_req = 1'b0;
            end
            if (tx_bits.req) begin
                if (have_req) begin
                    assert (cycle - last_req_cycle == `PICC_TX_BIT_PERIOD)
                    else report_mismatch("tx_bits.req spacing", `PICC_TX_BIT_PERIOD,
                                         cycle - last_req_cycle);
                end else begin
                    first_req_cycle = cycle;
                end
                have_req       = 1'b1;
                last_req_cycle = cycle;
                seen_bits.push_back(tx_bits.data);
            end
        end
    end

    task automatic step_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // random payload followed by its CRC, low byte first
    function automatic byte_q_t make_frame(input int n_bytes);
        byte_q_t     frame;
        logic [15:0] crc;
        for (int i = 0; i < n_bytes; i++) begin
            frame.push_back(8'($urandom));
        end
        crc = crc_a_of_bytes(frame);
        frame.push_back(crc[7:0]);
        frame.push_back(crc[15:8]);
        return frame;
    endfunction

    // one bit every other cycle, flip_pos selects a bit to corrupt
    task automatic send_rx_frame(input byte_q_t bytes, input int flip_pos);
        logic [7:0] cur;
        int         pos;
        int         k;
        pos = 0;
        rx_bits.soc = 1'b1;
        step_cycle();
        rx_bits.soc = 1'b0;
        step_cycle();
        foreach (bytes[i]) begin
            cur = bytes[i];
            for (k = 0; k < 8; k++) begin
                rx_bits.data_valid = 1'b1;
                rx_bits.data       = cur[0] ^ (pos == flip_pos);
                step_cycle();
                rx_bits.data_valid = 1'b0;
                step_cycle();
                cur = cur >> 1;
                pos++;
            end
        end
        rx_bits.eoc = 1'b1;
        eoc_cycle   = cycle;
        step_cycle();
        rx_bits.eoc = 1'b0;
    endtask

    // rx_crc_ok is looked at in the second cycle after eoc
    task automatic check_rx_result(input logic expected);
        @(posedge clk);
        @(negedge clk);
        assert (rx_crc_ok == expected)
        else report_mismatch("rx_crc_ok", 32'(expected), 32'(rx_crc_ok));
    endtask

    // a reader request, then an answer of n_bytes through the serializer
    task automatic run_tx_frame(input int n_bytes, input logic append);
        byte_q_t     data;
        byte_q_t     expect_bytes;
        logic [15:0] crc;
        logic [7:0]  cur;
        int          base;
        int          nbits;
        for (int i = 0; i < n_bytes; i++) begin
            data.push_back(8'($urandom));
        end
        expect_bytes = data;
        if (append) begin
            crc = crc_a_of_bytes(data);
            expect_bytes.push_back(crc[7:0]);
            expect_bytes.push_back(crc[15:8]);
        end
        nbits = expect_bytes.size() * 8;
        base  = seen_bits.size();
        tx_append_crc = append;

        send_rx_frame(make_frame(2), -1);
        check_rx_result(1'b1);
        step_cycle();

        // the source holds each byte until it sees ready
        foreach (data[i]) begin
            tx_byte.data  = data[i];
            tx_byte.last  = (i == data.size() - 1);
            tx_byte_valid = 1'b1;
            byte_offered  = 1'b1;
            do @(negedge clk); while (!tx_byte_ready);
            step_cycle();
        end
        tx_byte_valid = 1'b0;

        while (seen_bits.size() < base + nbits) begin
            @(posedge clk);
        end
        // the cycle after the final bit closes the frame
        @(negedge clk);
        assert (!tx_bits.data_valid)
        else report_mismatch("tx_bits.data_valid", 32'h0, 32'(tx_bits.data_valid));
        assert (first_req_cycle - eoc_cycle == `PICC_FDT_CYCLES + 1)
        else report_mismatch("first tx_bits.req delay", `PICC_FDT_CYCLES + 1,
                             first_req_cycle - eoc_cycle);

        for (int i = 0; i < nbits; i++) begin
            cur = expect_bytes[i / 8] >> (i % 8);
            assert (seen_bits[base + i] == cur[0])
            else report_mismatch($sformatf("tx_bits.data bit %0d", i), 32'(cur[0]),
                                 32'(seen_bits[base + i]));
        end

        repeat (`PICC_TX_BIT_PERIOD) @(posedge clk);
        assert (seen_bits.size() == base + nbits)
        else report_mismatch("tx bit count", base + nbits, seen_bits.size());
        #DRIVE_DELAY;
    endtask

    initial begin
        byte_q_t frame;
        int      flip_pos;
        void'($urandom(32'hf793));
        rst_n         = 1'b0;
        rx_bits       = '0;
        tx_byte       = '0;
        tx_byte_valid = 1'b0;
        tx_append_crc = 1'b0;
        repeat (16) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        step_cycle();

        // good frame, corrupted frame, good frame, each one well inside the FDT
        for (int f = 0; f < 3; f++) begin
            frame    = make_frame(int'($urandom_range(MAX_RX_BYTES, 2)));
            flip_pos = -1;
            if (f == 1) begin
                flip_pos = int'($urandom_range(frame.size() * 8 - 1, 0));
            end
            send_rx_frame(frame, flip_pos);
            check_rx_result(f != 1);
            step_cycle();
        end

        run_tx_frame(int'($urandom_range(MAX_TX_BYTES, 1)), 1'b1);
        run_tx_frame(int'($urandom_range(MAX_TX_BYTES, 1)), 1'b0);
        run_tx_frame(int'($urandom_range(MAX_TX_BYTES, 1)), 1'b1);

        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+src
+incdir+dv
src/frame_pkg.sv
src/crc_pkg.sv
src/crc_a.sv
src/crc_control.sv
src/fdt_timer.sv
src/tx_bit_serializer.sv
src/picc_crc_top.sv
dv/picc_crc_tb.sv

//--- run.sh
#!/bin/sh
# compile the PICC frame check testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module picc_crc_tb -o picc_crc_sim

# the simulator exit code is hidden by tee, the log decides
./obj_dir/picc_crc_sim 2>&1 | tee sim.log

if grep -q "Done: no errors" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
